/* Makefile */
VERILATOR ?= verilator
TOP       ?= ing_buf_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
ing_buf_pkg.sv
ing_buf_mem.sv
ing_buf_writer.sv
ing_buf_reader.sv
ing_buf_top.sv
tb_clkgen.sv
ing_buf_chk.sv
ing_buf_tb.sv

/* ing_buf_chk.sv */
// Handshake and reset checks on the ingress buffer top level
`timescale 1ns/1ns

module ing_buf_chk #(
    parameter int NUM_PORTS = 4
) (
    input logic                   ing_bus,
    input logic                   rst_n,
    input logic [NUM_PORTS-1:0]   in_ready,
    input logic                   out_valid,
    input logic                   out_ready,
    input ing_buf_pkg::bus_word_t out_word,
    input ing_buf_pkg::ing_meta_t out_meta,
    input logic [NUM_PORTS-1:0]   overflow
);

    // A stalled egress word holds until it is taken
    a_out_hold: assert property (@(posedge ing_bus) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_word) && $stable(out_meta))
        else $error("egress word or metadata changed while stalled");

    // Exactly one port owns the write slot once running
    a_ready_onehot: assert property (@(posedge ing_bus) disable iff (!rst_n)
        $past(rst_n) |-> $onehot(in_ready))
        else $error("in_ready is not one-hot: %b", in_ready);

    a_reset_quiet: assert property (@(posedge ing_bus)
        $rose(rst_n) |-> !out_valid && (overflow == '0))
        else $error("out_valid or overflow high right after reset");

endmodule

/* ing_buf_mem.sv */
// Ingress buffer storage
// Partitioned word store with registered read, descriptor store with async read
`timescale 1ns/1ns

module ing_buf_mem #(
    parameter int NUM_PORTS      = 4,
    parameter int WORDS_PER_PORT = 32,
    parameter int PKTS_PER_PORT  = 4
) (
    input  logic                                    ing_bus,
    input  logic                                    word_we,
    input  logic [ing_buf_pkg::port_w(NUM_PORTS)+$clog2(WORDS_PER_PORT)-1:0] word_waddr,
    input  logic [ing_buf_pkg::DATA_BYTES*8-1:0]     word_wdata,
    input  logic [ing_buf_pkg::port_w(NUM_PORTS)+$clog2(WORDS_PER_PORT)-1:0] word_raddr,
    input  logic                                    desc_we,
    input  logic [ing_buf_pkg::port_w(NUM_PORTS)+$clog2(PKTS_PER_PORT)-1:0] desc_waddr,
    input  ing_buf_pkg::pkt_desc_t                  desc_wdata,
    input  logic [ing_buf_pkg::port_w(NUM_PORTS)+$clog2(PKTS_PER_PORT)-1:0] desc_raddr,
    output logic [ing_buf_pkg::DATA_BYTES*8-1:0]     word_rdata,
    output ing_buf_pkg::pkt_desc_t                  desc_rdata
);

    import ing_buf_pkg::*;

    // Port number sits above the partition pointer in both address maps
    logic [DATA_BYTES*8-1:0] word_mem [NUM_PORTS*WORDS_PER_PORT];
    pkt_desc_t               desc_mem [NUM_PORTS*PKTS_PER_PORT];

    always_ff @(posedge ing_bus) begin
        if (word_we) begin
            word_mem[word_waddr] <= word_wdata;
        end
        word_rdata <= word_mem[word_raddr];
    end

    always_ff @(posedge ing_bus) begin
        if (desc_we) begin
            desc_mem[desc_waddr] <= desc_wdata;
        end
    end

    // Distributed-style read
    assign desc_rdata = desc_mem[desc_raddr];

endmodule

/* ing_buf_pkg.sv */
// Ingress buffer shared types
// Bus word, packet descriptor, egress metadata and width helpers
package ing_buf_pkg;

    // Bus geometry and field widths
    localparam int DATA_BYTES = 8;
    localparam int BYTE_IDX_W = $clog2(DATA_BYTES);
    localparam int KEEP_CNT_W = BYTE_IDX_W + 1;
    localparam int PORT_ID_W  = 4;
    localparam int LEN_W      = 11;
    localparam int PTR_W      = 8;

    typedef struct packed {
        logic [DATA_BYTES*8-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
    } bus_word_t;

    typedef struct packed {
        logic [PTR_W-1:0] last_ptr;
        logic [LEN_W-1:0] byte_len;
    } pkt_desc_t;

    typedef struct packed {
        logic [PORT_ID_W-1:0] ingress_port;
        logic [LEN_W-1:0]     byte_len;
    } ing_meta_t;

    // Port index width, one bit even for a single port
    function automatic int port_w(input int num_ports);
        return (num_ports > 1) ? $clog2(num_ports) : 1;
    endfunction

    // Number of valid bytes in a contiguous keep mask
    function automatic logic [KEEP_CNT_W-1:0] keep_count(input logic [DATA_BYTES-1:0] keep);
        logic [KEEP_CNT_W-1:0] n;
        n = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            n = n + KEEP_CNT_W'(keep[i]);
        end
        return n;
    endfunction

    // Last-word keep from the length remainder, zero means a full word
    function automatic logic [DATA_BYTES-1:0] keep_mask(input logic [BYTE_IDX_W-1:0] rem);
        logic [DATA_BYTES-1:0] m;
        m = '1;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (rem != '0 && i >= rem) begin
                m[i] = 1'b0;
            end
        end
        return m;
    endfunction

endpackage

/* ing_buf_reader.sv */
// Egress read side
// Round-robin packet scheduler, two-stage read pipeline and two-entry output queue
`timescale 1ns/1ns

module ing_buf_reader #(
    parameter int NUM_PORTS      = 4,
    parameter int WORDS_PER_PORT = 32,
    parameter int PKTS_PER_PORT  = 4
) (
    input  logic                                ing_bus,
    input  logic                                rst_n,
    input  logic [$clog2(PKTS_PER_PORT):0]      desc_wr_ptr [NUM_PORTS],
    input  ing_buf_pkg::pkt_desc_t              desc_rdata,
    input  logic [ing_buf_pkg::DATA_BYTES*8-1:0] word_rdata,
    input  logic                                out_ready,
    output logic [ing_buf_pkg::port_w(NUM_PORTS)+$clog2(PKTS_PER_PORT)-1:0] desc_raddr,
    output logic [ing_buf_pkg::port_w(NUM_PORTS)+$clog2(WORDS_PER_PORT)-1:0] word_raddr,
    output logic [$clog2(WORDS_PER_PORT)-1:0]   word_rd_ptr [NUM_PORTS],
    output logic [$clog2(PKTS_PER_PORT):0]      desc_rd_ptr [NUM_PORTS],
    output logic                                out_valid,
    output ing_buf_pkg::bus_word_t              out_word,
    output ing_buf_pkg::ing_meta_t              out_meta
);

    import ing_buf_pkg::*;

    localparam int PORT_W = port_w(NUM_PORTS);
    localparam int WPTR_W = $clog2(WORDS_PER_PORT);
    localparam int DPTR_W = $clog2(PKTS_PER_PORT);

    typedef struct packed {
        bus_word_t word;
        ing_meta_t meta;
    } q_entry_t;

    logic              [PORT_W-1:0] rsel;
    logic              [DPTR_W:0]   dwr_q [NUM_PORTS];
    logic                           pend;
    logic                           room;
    logic                           issue;
    logic                           at_last;
    logic              [2:0]        inflight;

    // Stage 0 is the read in the memory, stage 1 the word at word_rdata
    logic              s0_valid;
    logic              s0_last;
    logic [PORT_W-1:0] s0_port;
    pkt_desc_t         s0_desc;
    logic              s1_valid;
    logic              s1_last;
    logic [PORT_W-1:0] s1_port;
    pkt_desc_t         s1_desc;
    q_entry_t          s1_entry;

    q_entry_t          q_mem [2];
    logic              q_wr_idx;
    logic              q_rd_idx;
    logic [1:0]        q_cnt;
    logic              pop;

    assign desc_raddr = {rsel, desc_rd_ptr[rsel][DPTR_W-1:0]};

    always_comb begin
        pend     = dwr_q[rsel] != desc_rd_ptr[rsel];
        at_last  = word_rd_ptr[rsel] == desc_rdata.last_ptr[WPTR_W-1:0];
        pop      = out_valid && out_ready;
        // Queue entries plus reads still in the pipe, less the word leaving now
        inflight = 3'(q_cnt) + 3'(s0_valid) + 3'(s1_valid);
        room     = inflight < (3'd2 + 3'(pop));
        issue    = pend && room;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scheduler and pointers

    always_ff @(posedge ing_bus) begin
        if (!rst_n) begin
            rsel        <= '0;
            dwr_q       <= '{default: '0};
            word_rd_ptr <= '{default: '0};
            desc_rd_ptr <= '{default: '0};
            s0_valid    <= 1'b0;
            s1_valid    <= 1'b0;
        end else begin
            dwr_q    <= desc_wr_ptr;
            s0_valid <= issue;
            s1_valid <= s0_valid;
            if (issue) begin
                word_rd_ptr[rsel] <= word_rd_ptr[rsel] + 1'b1;
                if (at_last) begin
                    desc_rd_ptr[rsel] <= desc_rd_ptr[rsel] + 1'b1;
                end
            end
            // Stay on a port for the whole packet, otherwise rotate
            if (!pend || (issue && at_last)) begin
                rsel <= (rsel == PORT_W'(NUM_PORTS-1)) ? '0 : rsel + 1'b1;
            end
        end
    end

    always_ff @(posedge ing_bus) begin
        word_raddr <= {rsel, word_rd_ptr[rsel]};
        s0_last    <= at_last;
        s0_port    <= rsel;
        s0_desc    <= desc_rdata;
        s1_last    <= s0_last;
        s1_port    <= s0_port;
        s1_desc    <= s0_desc;
    end

    always_comb begin
        s1_entry.word.data         = word_rdata;
        s1_entry.word.keep         = s1_last ? keep_mask(s1_desc.byte_len[BYTE_IDX_W-1:0]) : '1;
        s1_entry.word.last         = s1_last;
        s1_entry.meta.ingress_port = PORT_ID_W'(s1_port);
        s1_entry.meta.byte_len     = s1_desc.byte_len;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output queue

    always_ff @(posedge ing_bus) begin
        if (!rst_n) begin
            q_wr_idx <= 1'b0;
            q_rd_idx <= 1'b0;
            q_cnt    <= '0;
        end else begin
            if (s1_valid) begin
                q_wr_idx <= !q_wr_idx;
            end
            if (pop) begin
                q_rd_idx <= !q_rd_idx;
            end
            q_cnt <= q_cnt + 2'(s1_valid) - 2'(pop);
        end
    end

    always_ff @(posedge ing_bus) begin
        if (s1_valid) begin
            q_mem[q_wr_idx] <= s1_entry;
        end
    end

    assign out_valid = q_cnt != '0;
    assign out_word  = q_mem[q_rd_idx].word;
    assign out_meta  = q_mem[q_rd_idx].meta;

endmodule

/* ing_buf_tb.sv */
// Ingress buffer testbench
// Table-driven packets on all ports, per-port scoreboard and egress monitor
`timescale 1ns/1ns

module ing_buf_tb;

    import ing_buf_pkg::*;

    localparam int NUM_PORTS      = 4;
    localparam int WORDS_PER_PORT = 32;
    localparam int PKTS_PER_PORT  = 4;
    localparam int RESET_CYCLES   = 8;
    localparam int SETTLE_CYCLES  = 8;
    localparam int NUM_ROWS       = 24;

    localparam logic [1:0] RDY_HIGH = 2'd0;
    localparam logic [1:0] RDY_LOW  = 2'd1;
    localparam logic [1:0] RDY_RAND = 2'd2;

    typedef struct packed {
        logic [79:0]          name;
        logic [PORT_ID_W-1:0] port;
        logic [LEN_W-1:0]     len;
        logic [7:0]           seed;
        logic [1:0]           mode;
        logic                 drop;
    } row_t;

    // Consecutive rows with one name form one test
    localparam row_t TBL [NUM_ROWS] = '{
        '{"single0",    4'd0, 11'd32, 8'h11, RDY_HIGH, 1'b0},
        '{"single1",    4'd1, 11'd16, 8'h12, RDY_HIGH, 1'b0},
        '{"single2",    4'd2, 11'd8,  8'h13, RDY_HIGH, 1'b0},
        '{"single3",    4'd3, 11'd40, 8'h14, RDY_HIGH, 1'b0},
        '{"remainder",  4'd1, 11'd1,  8'h21, RDY_HIGH, 1'b0},
        '{"remainder",  4'd1, 11'd9,  8'h22, RDY_HIGH, 1'b0},
        '{"remainder",  4'd1, 11'd63, 8'h23, RDY_HIGH, 1'b0},
        '{"remainder",  4'd1, 11'd64, 8'h24, RDY_HIGH, 1'b0},
        '{"all_ports",  4'd0, 11'd40, 8'h31, RDY_HIGH, 1'b0},
        '{"all_ports",  4'd1, 11'd24, 8'h32, RDY_HIGH, 1'b0},
        '{"all_ports",  4'd2, 11'd56, 8'h33, RDY_HIGH, 1'b0},
        '{"all_ports",  4'd3, 11'd8,  8'h34, RDY_HIGH, 1'b0},
        '{"all_ports",  4'd0, 11'd12, 8'h35, RDY_HIGH, 1'b0},
        '{"all_ports",  4'd2, 11'd5,  8'h36, RDY_HIGH, 1'b0},
        '{"rand_ready", 4'd0, 11'd30, 8'h41, RDY_RAND, 1'b0},
        '{"rand_ready", 4'd1, 11'd50, 8'h42, RDY_RAND, 1'b0},
        '{"rand_ready", 4'd2, 11'd7,  8'h43, RDY_RAND, 1'b0},
        '{"rand_ready", 4'd3, 11'd64, 8'h44, RDY_RAND, 1'b0},
        '{"hold_low",   4'd2, 11'd24, 8'h51, RDY_LOW,  1'b0},
        '{"hold_low",   4'd2, 11'd24, 8'h52, RDY_LOW,  1'b0},
        '{"hold_low",   4'd2, 11'd24, 8'h53, RDY_LOW,  1'b0},
        '{"hold_low",   4'd2, 11'd24, 8'h54, RDY_LOW,  1'b0},
        '{"hold_low",   4'd2, 11'd24, 8'h55, RDY_LOW,  1'b1},
        '{"after_drop", 4'd2, 11'd20, 8'h56, RDY_HIGH, 1'b0}
    };

    logic                 ing_bus;
    logic                 rst_n;
    logic [NUM_PORTS-1:0] in_valid;
    bus_word_t            in_word [NUM_PORTS];
    logic                 out_ready;
    logic [NUM_PORTS-1:0] in_ready;
    logic                 out_valid;
    bus_word_t            out_word;
    ing_meta_t            out_meta;
    logic [NUM_PORTS-1:0] overflow;

    // Scoreboard state
    bus_word_t   tx_q      [NUM_PORTS][$];
    bus_word_t   exp_q     [NUM_PORTS][$];
    int          exp_len_q [NUM_PORTS][$];
    int          ovf_cnt   [NUM_PORTS];
    logic [31:0] lfsr;
    logic [1:0]  ready_mode;
    logic        in_pkt;
    int          cur_port;
    int          err_cnt;
    int          test_err;
    int          pkt_cnt;

    tb_clkgen #(.PERIOD_NS(8), .RESET_CYCLES(RESET_CYCLES)) u_clkgen (
        .ing_bus (ing_bus),
        .rst_n   (rst_n)
    );

    ing_buf_top #(
        .NUM_PORTS      (NUM_PORTS),
        .WORDS_PER_PORT (WORDS_PER_PORT),
        .PKTS_PER_PORT  (PKTS_PER_PORT)
    ) u_dut (
        .ing_bus   (ing_bus),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_meta  (out_meta),
        .overflow  (overflow)
    );

    bind ing_buf_top ing_buf_chk #(.NUM_PORTS(NUM_PORTS)) u_chk (
        .ing_bus   (ing_bus),
        .rst_n     (rst_n),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_word  (out_word),
        .out_meta  (out_meta),
        .overflow  (overflow)
    );

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [7:0] pkt_byte(input logic [7:0] seed, input int idx);
        return seed ^ 8'(idx * 37) ^ 8'(idx >> 3);
    endfunction

    function automatic string name_str(input logic [79:0] n);
        string s;
        s = "";
        for (int i = 9; i >= 0; i--) begin
            if (n[i*8 +: 8] != 8'h00) begin
                s = {s, $sformatf("%c", n[i*8 +: 8])};
            end
        end
        return s;
    endfunction

    function automatic bit tx_idle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (tx_q[p].size() != 0) begin
                return 1'b0;
            end
        end
        return in_valid == '0;
    endfunction

    function automatic bit rx_idle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_q[p].size() != 0) begin
                return 1'b0;
            end
        end
        return !in_pkt;
    endfunction

    task automatic note_error();
        err_cnt++;
        test_err++;
    endtask

    // Split one table row into bus words, keep contiguous from byte 0
    task automatic queue_packet(input row_t r);
        int        nwords;
        int        idx;
        int        p;
        bus_word_t w;
        p = int'(r.port);
        nwords = (int'(r.len) + DATA_BYTES - 1) / DATA_BYTES;
        for (int i = 0; i < nwords; i++) begin
            w = '0;
            for (int b = 0; b < DATA_BYTES; b++) begin
                idx = i * DATA_BYTES + b;
                if (idx < int'(r.len)) begin
                    w.data[b*8 +: 8] = pkt_byte(r.seed, idx);
                    w.keep[b]        = 1'b1;
                end
            end
            w.last = (i == nwords - 1);
            tx_q[p].push_back(w);
            if (!r.drop) begin
                exp_q[p].push_back(w);
            end
        end
        if (!r.drop) begin
            exp_len_q[p].push_back(int'(r.len));
        end
    endtask

    task automatic check_word();
        int        p;
        bus_word_t e;
        p = int'(out_meta.ingress_port);
        if (in_pkt && p != cur_port) begin
            $display("egress word from port %0d cut into a packet from port %0d", p, cur_port);
            note_error();
        end
        if (p >= NUM_PORTS || exp_q[p].size() == 0) begin
            $display("egress word from port %0d arrived with no packet expected", p);
            note_error();
        end else begin
            e = exp_q[p].pop_front();
            if (out_word.data !== e.data) begin
                $display("[FAIL] out_word.data port %0d expected 0x%h got 0x%h",
                         p, e.data, out_word.data);
                note_error();
            end
            if (out_word.keep !== e.keep || out_word.last !== e.last) begin
                $display("[FAIL] out_word.keep/last port %0d expected 0x%h/0x%h got 0x%h/0x%h",
                         p, e.keep, e.last, out_word.keep, out_word.last);
                note_error();
            end
            if (out_meta.byte_len !== LEN_W'(exp_len_q[p][0])) begin
                $display("[FAIL] out_meta.byte_len port %0d expected 0x%h got 0x%h",
                         p, LEN_W'(exp_len_q[p][0]), out_meta.byte_len);
                note_error();
            end
            if (e.last) begin
                void'(exp_len_q[p].pop_front());
                in_pkt = 1'b0;
                pkt_cnt++;
            end else begin
                in_pkt   = 1'b1;
                cur_port = p;
            end
        end
    endtask

    // Sample mid-cycle, drive 1 ns after the rising edge
    task automatic step_cycle();
        logic [NUM_PORTS-1:0] taken;
        @(negedge ing_bus);
        taken = in_valid & in_ready;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (overflow[p]) begin
                ovf_cnt[p]++;
            end
        end
        if (out_valid && out_ready) begin
            check_word();
        end
        @(posedge ing_bus);
        #1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (taken[p]) begin
                void'(tx_q[p].pop_front());
            end
            in_valid[p] = tx_q[p].size() != 0;
            in_word[p]  = (tx_q[p].size() != 0) ? tx_q[p][0] : '0;
        end
        if (ready_mode == RDY_RAND) begin
            lfsr      = lfsr_step(lfsr);
            out_ready = lfsr[0];
        end else begin
            out_ready = (ready_mode == RDY_HIGH);
        end
    endtask

    task automatic run_test(input int first, input int last_row);
        int exp_drops [NUM_PORTS];
        int ovf_start [NUM_PORTS];
        test_err   = 0;
        ready_mode = TBL[first].mode;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_drops[p] = 0;
            ovf_start[p] = ovf_cnt[p];
        end
        for (int r = first; r <= last_row; r++) begin
            queue_packet(TBL[r]);
            if (TBL[r].drop) begin
                exp_drops[TBL[r].port]++;
            end
        end
        while (!tx_idle()) begin
            step_cycle();
        end
        repeat (SETTLE_CYCLES) step_cycle();
        // Stored packets drain once the egress opens
        if (ready_mode == RDY_LOW) begin
            ready_mode = RDY_HIGH;
        end
        while (!rx_idle()) begin
            step_cycle();
        end
        repeat (SETTLE_CYCLES) step_cycle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (ovf_cnt[p] - ovf_start[p] != exp_drops[p]) begin
                $display("[FAIL] overflow[%0d] pulses expected 0x%h got 0x%h",
                         p, exp_drops[p], ovf_cnt[p] - ovf_start[p]);
                note_error();
            end
        end
        $display("test %s: %0d packets, %0d errors",
                 name_str(TBL[first].name), last_row - first + 1, test_err);
    endtask

    initial begin : main
        int first;
        int last_row;
        int test_cnt;
        int fail_tests;
        in_valid   = '0;
        in_word    = '{default: '0};
        out_ready  = 1'b0;
        lfsr       = 32'h9cf;
        ready_mode = RDY_HIGH;
        in_pkt     = 1'b0;
        cur_port   = 0;
        err_cnt    = 0;
        test_err   = 0;
        pkt_cnt    = 0;
        ovf_cnt    = '{default: 0};
        test_cnt   = 0;
        fail_tests = 0;
        first      = 0;
        wait (rst_n === 1'b1);
        while (first < NUM_ROWS) begin
            last_row = first;
            while (last_row + 1 < NUM_ROWS && TBL[last_row + 1].name == TBL[first].name) begin
                last_row++;
            end
            run_test(first, last_row);
            test_cnt++;
            if (test_err != 0) begin
                fail_tests++;
            end
            first = last_row + 1;
        end
        $display("tests %0d, failed %0d, packets out %0d, errors %0d",
                 test_cnt, fail_tests, pkt_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // 40 cycles per packet word plus a fixed margin
    initial begin : watchdog
        int limit;
        limit = 2000 + RESET_CYCLES;
        for (int i = 0; i < NUM_ROWS; i++) begin
            limit += 40 * ((int'(TBL[i].len) + DATA_BYTES - 1) / DATA_BYTES);
        end
        repeat (limit) @(posedge ing_bus);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* ing_buf_top.sv */
// Ingress buffer top level
// Writer and reader around the shared word and descriptor stores
`timescale 1ns/1ns

module ing_buf_top #(
    parameter int NUM_PORTS      = 4,
    parameter int WORDS_PER_PORT = 32,
    parameter int PKTS_PER_PORT  = 4
) (
    input  logic                   ing_bus,
    input  logic                   rst_n,
    input  logic [NUM_PORTS-1:0]   in_valid,
    input  ing_buf_pkg::bus_word_t in_word [NUM_PORTS],
    input  logic                   out_ready,
    output logic [NUM_PORTS-1:0]   in_ready,
    output logic                   out_valid,
    output ing_buf_pkg::bus_word_t out_word,
    output ing_buf_pkg::ing_meta_t out_meta,
    output logic [NUM_PORTS-1:0]   overflow
);

    import ing_buf_pkg::*;

    localparam int PORT_W  = port_w(NUM_PORTS);
    localparam int WPTR_W  = $clog2(WORDS_PER_PORT);
    localparam int DPTR_W  = $clog2(PKTS_PER_PORT);
    localparam int WADDR_W = PORT_W + WPTR_W;
    localparam int DADDR_W = PORT_W + DPTR_W;

    logic                    word_we;
    logic [WADDR_W-1:0]      word_waddr;
    logic [DATA_BYTES*8-1:0] word_wdata;
    logic [WADDR_W-1:0]      word_raddr;
    logic [DATA_BYTES*8-1:0] word_rdata;
    logic                    desc_we;
    logic [DADDR_W-1:0]      desc_waddr;
    pkt_desc_t               desc_wdata;
    logic [DADDR_W-1:0]      desc_raddr;
    pkt_desc_t               desc_rdata;

    // Pointer exchange between the two sides
    logic [DPTR_W:0]         desc_wr_ptr [NUM_PORTS];
    logic [WPTR_W-1:0]       word_rd_ptr [NUM_PORTS];
    logic [DPTR_W:0]         desc_rd_ptr [NUM_PORTS];

    ing_buf_writer #(
        .NUM_PORTS      (NUM_PORTS),
        .WORDS_PER_PORT (WORDS_PER_PORT),
        .PKTS_PER_PORT  (PKTS_PER_PORT)
    ) u_writer (
        .ing_bus     (ing_bus),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_word     (in_word),
        .word_rd_ptr (word_rd_ptr),
        .desc_rd_ptr (desc_rd_ptr),
        .in_ready    (in_ready),
        .overflow    (overflow),
        .word_we     (word_we),
        .word_waddr  (word_waddr),
        .word_wdata  (word_wdata),
        .desc_we     (desc_we),
        .desc_waddr  (desc_waddr),
        .desc_wdata  (desc_wdata),
        .desc_wr_ptr (desc_wr_ptr)
    );

    ing_buf_mem #(
        .NUM_PORTS      (NUM_PORTS),
        .WORDS_PER_PORT (WORDS_PER_PORT),
        .PKTS_PER_PORT  (PKTS_PER_PORT)
    ) u_mem (
        .ing_bus    (ing_bus),
        .word_we    (word_we),
        .word_waddr (word_waddr),
        .word_wdata (word_wdata),
        .word_raddr (word_raddr),
        .desc_we    (desc_we),
        .desc_waddr (desc_waddr),
        .desc_wdata (desc_wdata),
        .desc_raddr (desc_raddr),
        .word_rdata (word_rdata),
        .desc_rdata (desc_rdata)
    );

    ing_buf_reader #(
        .NUM_PORTS      (NUM_PORTS),
        .WORDS_PER_PORT (WORDS_PER_PORT),
        .PKTS_PER_PORT  (PKTS_PER_PORT)
    ) u_reader (
        .ing_bus     (ing_bus),
        .rst_n       (rst_n),
        .desc_wr_ptr (desc_wr_ptr),
        .desc_rdata  (desc_rdata),
        .word_rdata  (word_rdata),
        .out_ready   (out_ready),
        .desc_raddr  (desc_raddr),
        .word_raddr  (word_raddr),
        .word_rd_ptr (word_rd_ptr),
        .desc_rd_ptr (desc_rd_ptr),
        .out_valid   (out_valid),
        .out_word    (out_word),
        .out_meta    (out_meta)
    );

endmodule

/* ing_buf_writer.sv */
// Ingress write side
// Round-robin word scheduler with per-port commit, drop and overflow handling
`timescale 1ns/1ns

module ing_buf_writer #(
    parameter int NUM_PORTS      = 4,
    parameter int WORDS_PER_PORT = 32,
    parameter int PKTS_PER_PORT  = 4
) (
    input  logic                                ing_bus,
    input  logic                                rst_n,
    input  logic [NUM_PORTS-1:0]                in_valid,
    input  ing_buf_pkg::bus_word_t              in_word [NUM_PORTS],
    input  logic [$clog2(WORDS_PER_PORT)-1:0]   word_rd_ptr [NUM_PORTS],
    input  logic [$clog2(PKTS_PER_PORT):0]      desc_rd_ptr [NUM_PORTS],
    output logic [NUM_PORTS-1:0]                in_ready,
    output logic [NUM_PORTS-1:0]                overflow,
    output logic                                word_we,
    output logic [ing_buf_pkg::port_w(NUM_PORTS)+$clog2(WORDS_PER_PORT)-1:0] word_waddr,
    output logic [ing_buf_pkg::DATA_BYTES*8-1:0] word_wdata,
    output logic                                desc_we,
    output logic [ing_buf_pkg::port_w(NUM_PORTS)+$clog2(PKTS_PER_PORT)-1:0] desc_waddr,
    output ing_buf_pkg::pkt_desc_t              desc_wdata,
    output logic [$clog2(PKTS_PER_PORT):0]      desc_wr_ptr [NUM_PORTS]
);

    import ing_buf_pkg::*;

    localparam int PORT_W = port_w(NUM_PORTS);
    localparam int WPTR_W = $clog2(WORDS_PER_PORT);
    localparam int DPTR_W = $clog2(PKTS_PER_PORT);
    localparam int WCNT_W = LEN_W - BYTE_IDX_W;

    logic              run;
    logic [PORT_W-1:0] sel;
    logic [WPTR_W-1:0] wr_ptr  [NUM_PORTS];
    logic [WPTR_W-1:0] cmt_ptr [NUM_PORTS];
    // Descriptor slots taken at acceptance, exported one cycle later
    logic [DPTR_W:0]   d_alloc [NUM_PORTS];
    logic [WCNT_W-1:0] wcnt    [NUM_PORTS];
    logic [NUM_PORTS-1:0] drop;

    bus_word_t         cur_word;
    logic              cur_valid;
    logic              full_w;
    logic              full_d;
    logic              discard;
    logic [DPTR_W:0]   d_used;
    logic [LEN_W-1:0]  byte_len;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_ready
        assign in_ready[p] = run && (sel == PORT_W'(p));
    end

    always_comb begin
        cur_word  = in_word[sel];
        cur_valid = run && in_valid[sel];
        d_used    = d_alloc[sel] - desc_rd_ptr[sel];
        full_w    = WPTR_W'(wr_ptr[sel] + 1'b1) == word_rd_ptr[sel];
        full_d    = d_used == (DPTR_W+1)'(PKTS_PER_PORT);
        discard   = drop[sel] || full_w || full_d;
        // Full words before the last, plus the bytes of this one
        byte_len  = {wcnt[sel], BYTE_IDX_W'(0)} + LEN_W'(keep_count(cur_word.keep));
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control state

    always_ff @(posedge ing_bus) begin
        if (!rst_n) begin
            run         <= 1'b0;
            sel         <= '0;
            wr_ptr      <= '{default: '0};
            cmt_ptr     <= '{default: '0};
            d_alloc     <= '{default: '0};
            desc_wr_ptr <= '{default: '0};
            wcnt        <= '{default: '0};
            drop        <= '0;
            overflow    <= '0;
            word_we     <= 1'b0;
            desc_we     <= 1'b0;
        end else begin
            run         <= 1'b1;
            overflow    <= '0;
            word_we     <= 1'b0;
            desc_we     <= 1'b0;
            desc_wr_ptr <= d_alloc;
            // Slot moves on every cycle, data or not
            if (run) begin
                sel <= (sel == PORT_W'(NUM_PORTS-1)) ? '0 : sel + 1'b1;
            end
            if (cur_valid) begin
                if (discard) begin
                    // Throw the packet away and give its words back
                    drop[sel]     <= !cur_word.last;
                    wr_ptr[sel]   <= cmt_ptr[sel];
                    overflow[sel] <= cur_word.last;
                end else begin
                    word_we     <= 1'b1;
                    wr_ptr[sel] <= wr_ptr[sel] + 1'b1;
                    if (cur_word.last) begin
                        desc_we      <= 1'b1;
                        cmt_ptr[sel] <= wr_ptr[sel] + 1'b1;
                        d_alloc[sel] <= d_alloc[sel] + 1'b1;
                    end
                end
                wcnt[sel] <= cur_word.last ? '0 : wcnt[sel] + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write payload, qualified by word_we and desc_we

    always_ff @(posedge ing_bus) begin
        word_waddr          <= {sel, wr_ptr[sel]};
        word_wdata          <= cur_word.data;
        desc_waddr          <= {sel, d_alloc[sel][DPTR_W-1:0]};
        desc_wdata.last_ptr <= PTR_W'(wr_ptr[sel]);
        desc_wdata.byte_len <= byte_len;
    end

endmodule

/* tb_clkgen.sv */
// Testbench clock and reset source
`timescale 1ns/1ns

module tb_clkgen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic ing_bus,
    output logic rst_n
);

    initial begin
        ing_bus = 1'b0;
        forever #(PERIOD_NS / 2) ing_bus = ~ing_bus;
    end

    // Release lands just after an edge, like the other driven inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge ing_bus);
        #1 rst_n = 1'b1;
    end

endmodule
